/* src/zx_paging_pkg.sv */
//==============================
// Shared types for the Spectrum paging unit.
// Address, byte, bank and machine encodings used by
// the port decoders, the mapper and the top level.
//==============================

package zx_paging_pkg;

	// CPU side
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;

	//==============================
	// Page geometry
	// A 16K page takes the low 14 address bits
	localparam int PAGE_BITS = 14;

	typedef logic [PAGE_BITS-1:0] page_offset_t;

	// Physical bank number
	// Bit 3 set means ROM, then bits 1..0 give the ROM index.
	// With bit 3 clear, bits 2..0 give the RAM bank 0..7.
	typedef logic [3:0] bank_t;

	// Bank on top, offset inside the page below
	typedef logic [$bits(bank_t)+PAGE_BITS-1:0] phys_addr_t;

	//==============================
	// Machine type
	// Sampled into the unit while reset is high
	typedef enum logic [1:0] {
		ARCH_48    = 2'd0,
		ARCH_128   = 2'd1,
		ARCH_PLUS3 = 2'd2
	} arch_t;

endpackage

/* src/cpu_bus_if.sv */
//==============================
// CPU bus as seen by the paging unit.
// Driven from the top-level ports, read by both port
// decoders and by the memory mapper.
//==============================

`timescale 1ns/1ps

interface cpu_bus_if;

	zx_paging_pkg::cpu_addr_t addr;
	zx_paging_pkg::byte_t     data;
	// High through a whole I/O write cycle
	logic                     io_wr;
	logic                     mem_rd;
	logic                     mem_wr;

	// Port decoders only look at I/O writes
	modport decoder (input addr, data, io_wr);

	modport mapper (input addr, mem_rd, mem_wr);

	// Top-level side
	modport source (output addr, data, io_wr, mem_rd, mem_wr);

endinterface

/* src/paging_if.sv */
//==============================
// Paging register fields.
// The 7FFD decoder owns the machine type, its register
// and the lock, the 1FFD decoder owns the +3 register.
// The mapper reads all of them.
//==============================

`timescale 1ns/1ps

interface paging_if;

	// Machine type, latched during reset
	zx_paging_pkg::arch_t arch;

	// 128K paging register
	zx_paging_pkg::byte_t reg_7ffd;

	// Paging disabled, either 48K or 7FFD bit 5
	logic                 locked;

	// +3 paging register
	zx_paging_pkg::byte_t reg_1ffd;

	modport port128 (
		output arch,
		output reg_7ffd,
		output locked
	);

	// +3 decoder honours the lock set through 7FFD
	modport port_plus3 (
		input  arch,
		input  locked,
		output reg_1ffd
	);

	modport mapper (input arch, reg_7ffd, locked, reg_1ffd);

endinterface

/* src/port_7ffd.sv */
//==============================
// 128K paging port decoder.
// Latches the machine type while reset is high, holds
// the 7FFD register and produces the paging lock.
//==============================

`timescale 1ns/1ps

module port_7ffd (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_paging_pkg::arch_t arch_in,
	cpu_bus_if.decoder           bus,
	paging_if.port128            pg
);

	zx_paging_pkg::arch_t arch_q;
	zx_paging_pkg::byte_t reg_q;
	logic                 io_wr_q;
	logic                 wr_edge;
	logic                 port_hit;
	logic                 locked;

	//==============================
	// Write decode
	// First clock with io_wr high after a low one
	assign wr_edge = bus.io_wr & ~io_wr_q;

	// A15 and A1 low; the +3 also needs A14 high
	assign port_hit = ~bus.addr[15] & ~bus.addr[1]
		& (bus.addr[14] | (arch_q != zx_paging_pkg::ARCH_PLUS3));

	// 48K has no paging at all
	assign locked = (arch_q == zx_paging_pkg::ARCH_48) | reg_q[5];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			arch_q  <= arch_in;
			reg_q   <= '0;
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= bus.io_wr;
			if (wr_edge && port_hit && !locked) begin
				reg_q <= bus.data;
			end
		end
	end

	assign pg.arch     = arch_q;
	assign pg.reg_7ffd = reg_q;
	assign pg.locked   = locked;

	//==============================
	// Once locked, only a reset can change the register
	locked_hold_a: assert property (
		@(posedge clk_sys) disable iff (reset)
		locked |=> $stable(reg_q)
	);

endmodule

/* src/port_1ffd.sv */
//==============================
// +3 paging port decoder.
// Holds the 1FFD register: special RAM modes, upper
// ROM bit and disk motor. Only active on the +3.
//==============================

`timescale 1ns/1ps

module port_1ffd (
	input  logic          clk_sys,
	input  logic          reset,
	cpu_bus_if.decoder    bus,
	paging_if.port_plus3  pg
);

	zx_paging_pkg::byte_t reg_q;
	logic                 io_wr_q;
	logic                 wr_edge;
	logic                 port_hit;

	// Own edge detector, same rule as the 7FFD side
	assign wr_edge = bus.io_wr & ~io_wr_q;

	// A15, A14, A13, A1 low and A12 high
	assign port_hit = ~bus.addr[15] & ~bus.addr[14] & ~bus.addr[13]
		& bus.addr[12] & ~bus.addr[1]
		& (pg.arch == zx_paging_pkg::ARCH_PLUS3) & ~pg.locked;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_q   <= '0;
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= bus.io_wr;
			if (wr_edge && port_hit) begin
				reg_q <= bus.data;
			end
		end
	end

	assign pg.reg_1ffd = reg_q;

	//==============================
	// Machine type comes from the 7FFD side
	plus3_only_a: assert property (
		@(posedge clk_sys) disable iff (reset)
		(pg.arch != zx_paging_pkg::ARCH_PLUS3) |-> (reg_q == '0)
	);

endmodule

/* src/mem_mapper.sv */
//==============================
// Memory mapper.
// Turns a CPU address into bank and offset from both
// paging registers, and gates RAM writes to ROM.
// Purely combinational.
//==============================

`timescale 1ns/1ps

module mem_mapper (
	cpu_bus_if.mapper                  bus,
	paging_if.mapper                   pg,
	output zx_paging_pkg::phys_addr_t  phys_addr,
	output logic                       ram_rd,
	output logic                       ram_we,
	output logic                       screen_page,
	output logic                       disk_motor
);

	logic [1:0]                  quarter;
	logic [1:0]                  rom_idx;
	logic [2:0]                  special_ram;
	logic                        special;
	zx_paging_pkg::bank_t        bank;
	zx_paging_pkg::page_offset_t offset;

	assign quarter = bus.addr[15:14];
	assign offset  = bus.addr[zx_paging_pkg::PAGE_BITS-1:0];
	assign special = pg.reg_1ffd[0];

	// ROM index per machine
	always_comb begin
		case (pg.arch)
			zx_paging_pkg::ARCH_PLUS3: rom_idx = {pg.reg_1ffd[2], pg.reg_7ffd[4]};
			zx_paging_pkg::ARCH_128:   rom_idx = {1'b0, pg.reg_7ffd[4]};
			default:                   rom_idx = 2'd3;
		endcase
	end

	//==============================
	// +3 all-RAM configurations
	always_comb begin
		case (pg.reg_1ffd[2:1])
			2'd0: special_ram = {1'b0, quarter};
			2'd1: special_ram = {1'b1, quarter};
			2'd2: special_ram = (quarter == 2'd3) ? 3'd3 : {1'b1, quarter};
			default: begin
				case (quarter)
					2'd0:    special_ram = 3'd4;
					2'd1:    special_ram = 3'd7;
					2'd2:    special_ram = 3'd6;
					default: special_ram = 3'd3;
				endcase
			end
		endcase
	end

	// Bank select and write gating
	always_comb begin
		if (special) begin
			bank = {1'b0, special_ram};
		end else begin
			case (quarter)
				2'd0:    bank = {2'b10, rom_idx};
				2'd1:    bank = 4'd5;
				2'd2:    bank = 4'd2;
				default: bank = {1'b0, pg.reg_7ffd[2:0]};
			endcase
		end
		ram_we = bus.mem_wr & ~bank[3];
		// ROM only ever sits in quarter 0 of the normal map
		assert (!(ram_we && !special && quarter == 2'd0));
	end

	assign phys_addr   = {bank, offset};
	assign ram_rd      = bus.mem_rd;
	assign screen_page = pg.reg_7ffd[3];
	assign disk_motor  = pg.reg_1ffd[3];

endmodule

/* src/zx_paging_unit.sv */
//==============================
// Paging unit top level.
// CPU bus in, physical bank and offset out. Port writes
// take effect one clock after the io_wr edge.
//==============================

`timescale 1ns/1ps

module zx_paging_unit (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  zx_paging_pkg::arch_t       arch,
	input  zx_paging_pkg::cpu_addr_t   addr,
	input  zx_paging_pkg::byte_t       data,
	input  logic                       io_wr,
	input  logic                       mem_rd,
	input  logic                       mem_wr,
	output zx_paging_pkg::phys_addr_t  phys_addr,
	output logic                       ram_rd,
	output logic                       ram_we,
	output logic                       screen_page,
	output logic                       disk_motor,
	output logic                       paging_locked
);

	cpu_bus_if bus_i ();
	paging_if  pg_i ();

	//==============================
	// CPU bus into the interface
	assign bus_i.addr   = addr;
	assign bus_i.data   = data;
	assign bus_i.io_wr  = io_wr;
	assign bus_i.mem_rd = mem_rd;
	assign bus_i.mem_wr = mem_wr;

	assign paging_locked = pg_i.locked;

	// Decoders side by side
	port_7ffd port_7ffd_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.arch_in (arch),
		.bus     (bus_i),
		.pg      (pg_i)
	);

	port_1ffd port_1ffd_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus_i),
		.pg      (pg_i)
	);

	//==============================
	// Address mapping
	mem_mapper mem_mapper_i (
		.bus         (bus_i),
		.pg          (pg_i),
		.phys_addr   (phys_addr),
		.ram_rd      (ram_rd),
		.ram_we      (ram_we),
		.screen_page (screen_page),
		.disk_motor  (disk_motor)
	);

endmodule

/* verif/tb_zx_paging_unit.sv */
//==============================
// Testbench for the paging unit.
// Replays the golden file step by step: reset with a
// machine type, port writes and checked memory accesses.
//==============================

`timescale 1ns/1ps

module tb_zx_paging_unit;

	localparam int MAX_CYCLES = 2000;
	localparam int MAX_STEPS  = 200;

	logic                      clk_sys;
	logic                      reset;
	zx_paging_pkg::arch_t      arch;
	zx_paging_pkg::cpu_addr_t  addr;
	zx_paging_pkg::byte_t      data;
	logic                      io_wr;
	logic                      mem_rd;
	logic                      mem_wr;
	zx_paging_pkg::phys_addr_t phys_addr;
	logic                      ram_rd;
	logic                      ram_we;
	logic                      screen_page;
	logic                      disk_motor;
	logic                      paging_locked;

	int checks = 0;
	int errors = 0;

	zx_paging_unit dut_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.arch          (arch),
		.addr          (addr),
		.data          (data),
		.io_wr         (io_wr),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.phys_addr     (phys_addr),
		.ram_rd        (ram_rd),
		.ram_we        (ram_we),
		.screen_page   (screen_page),
		.disk_motor    (disk_motor),
		.paging_locked (paging_locked)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//==============================
	// Compare tasks
	task automatic check_phys(input zx_paging_pkg::phys_addr_t exp,
		input zx_paging_pkg::phys_addr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at time %0t: phys_addr expected %05h, got %05h",
				$time, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Mismatch at time %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	//==============================
	// Bus steps
	// Inputs change 2 ns after a rising edge
	task automatic next_slot();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic apply_reset(input zx_paging_pkg::arch_t machine);
		next_slot();
		reset  = 1'b1;
		arch   = machine;
		io_wr  = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		repeat (2) next_slot();
		reset = 1'b0;
	endtask

	// io_wr high for two edges, then low for one
	task automatic io_write(input zx_paging_pkg::cpu_addr_t a, input zx_paging_pkg::byte_t d);
		next_slot();
		addr   = a;
		data   = d;
		io_wr  = 1'b1;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		repeat (2) next_slot();
		io_wr = 1'b0;
	endtask

	// Mapping is combinational, sampled at the next edge
	task automatic mem_access(input zx_paging_pkg::cpu_addr_t a, input logic rd,
		input logic wr, input zx_paging_pkg::phys_addr_t exp_phys, input logic exp_we,
		input logic exp_scr, input logic exp_mot, input logic exp_lck);
		next_slot();
		addr   = a;
		mem_rd = rd;
		mem_wr = wr;
		@(posedge clk_sys);
		check_phys(exp_phys, phys_addr);
		check_flag("ram_rd", rd, ram_rd);
		check_flag("ram_we", exp_we, ram_we);
		check_flag("screen_page", exp_scr, screen_page);
		check_flag("disk_motor", exp_mot, disk_motor);
		check_flag("paging_locked", exp_lck, paging_locked);
	endtask

	//==============================
	// Watchdog
	initial begin : watchdog
		int cycle;
		for (cycle = 0; cycle < MAX_CYCLES; cycle++) begin
			@(posedge clk_sys);
		end
		errors++;
		$display("Timeout: the golden replay did not finish within %0d cycles", MAX_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : replay
		int                        fd;
		int                        code;
		int                        steps;
		bit                        done;
		byte                       cmd;
		logic [8*160-1:0]          skipped;
		logic [1:0]                arch_v;
		zx_paging_pkg::cpu_addr_t  a_v;
		zx_paging_pkg::byte_t      d_v;
		zx_paging_pkg::phys_addr_t phys_v;
		logic                      rd_v;
		logic                      wr_v;
		logic                      we_v;
		logic                      scr_v;
		logic                      mot_v;
		logic                      lck_v;

		reset  = 1'b1;
		arch   = zx_paging_pkg::ARCH_128;
		addr   = '0;
		data   = '0;
		io_wr  = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		steps  = 0;
		done   = 1'b0;

		fd = $fopen("verif/paging_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("The golden file verif/paging_golden.txt could not be opened");
			done = 1'b1;
		end

		while (!done) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				done = 1'b1;
			end else if (steps >= MAX_STEPS) begin
				errors++;
				$display("The golden file has more than %0d steps, replay stopped", MAX_STEPS);
				done = 1'b1;
			end else begin
				case (cmd)
					"#": begin
						code = $fgets(skipped, fd);
						if (code > 0) begin
							code = 1;
						end
					end
					"R": begin
						code = $fscanf(fd, "%h", arch_v);
						if (code == 1) begin
							apply_reset(zx_paging_pkg::arch_t'(arch_v));
						end
					end
					"W": begin
						code = $fscanf(fd, "%h %h", a_v, d_v);
						if (code == 2) begin
							io_write(a_v, d_v);
							code = 1;
						end
					end
					"A": begin
						code = $fscanf(fd, "%h %h %h %h %h %h %h %h", a_v, rd_v, wr_v,
							phys_v, we_v, scr_v, mot_v, lck_v);
						if (code == 8) begin
							mem_access(a_v, rd_v, wr_v, phys_v, we_v, scr_v, mot_v, lck_v);
							code = 1;
						end
					end
					default: code = 0;
				endcase
				if (cmd != "#") begin
					steps++;
				end
				if (code != 1) begin
					errors++;
					$display("Golden step %0d (type %c) could not be read", steps, cmd);
					done = 1'b1;
				end
			end
		end

		if (fd != 0) begin
			$fclose(fd);
		end
		if (checks == 0) begin
			errors++;
			$display("No memory access was checked");
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

/* verif/paging_golden.txt */
# Steps: R arch | W addr data | A addr mem_rd mem_wr phys_addr ram_we screen disk_motor locked
# All values hex; arch 0 = 48K, 1 = 128K, 2 = +3; phys_addr is bank then 14-bit offset
# 128K after reset
R 1
A 0000 1 0 20000 0 0 0 0
A 4000 1 0 14000 0 0 0 0
A 8000 1 0 08000 0 0 0 0
A C000 1 0 00000 0 0 0 0
# 128K paging: bank 6, screen, ROM 1, then lock and an ignored write
W 7FFD 1E
A C123 1 0 18123 0 1 0 0
A 0000 1 0 24000 0 1 0 0
A E001 0 1 1A001 1 1 0 0
W 7FFD 23
A C000 1 0 0C000 0 0 0 1
W 7FFD 17
A C000 1 0 0C000 0 0 0 1
A 0000 1 0 20000 0 0 0 1
# 48K: locked, ROM 3 only
R 0
W 7FFD 07
A 0000 1 0 2C000 0 0 0 1
A C000 1 0 00000 0 0 0 1
A 0100 0 1 2C100 0 0 0 1
A 8000 0 1 08000 1 0 0 1
# +3 special all-RAM modes
R 2
W 1FFD 01
A 0000 0 1 00000 1 0 0 0
A 4000 1 0 04000 0 0 0 0
A 8000 1 0 08000 0 0 0 0
A C000 1 0 0C000 0 0 0 0
W 1FFD 03
A 0000 1 0 10000 0 0 0 0
A 4000 1 0 14000 0 0 0 0
A 8000 1 0 18000 0 0 0 0
A C000 1 0 1C000 0 0 0 0
W 1FFD 0D
A 0000 0 1 10000 1 0 1 0
A C000 1 0 0C000 0 0 1 0
W 1FFD 07
A 4000 1 0 1C000 0 0 0 0
A C000 1 0 0C000 0 0 0 0
# +3 normal mode ROM select; 3FFD must not reach 7FFD
R 2
W 3FFD 10
A 0000 1 0 20000 0 0 0 0
W 7FFD 10
A 0000 1 0 24000 0 0 0 0
W 1FFD 04
A 0000 1 0 2C000 0 0 0 0
W 7FFD 00
A 0000 1 0 28000 0 0 0 0
W 1FFD 08
A 0000 0 1 20000 0 0 1 0

/* zx_paging_unit.f */
src/zx_paging_pkg.sv
src/cpu_bus_if.sv
src/paging_if.sv
src/port_7ffd.sv
src/port_1ffd.sv
src/mem_mapper.sv
src/zx_paging_unit.sv
verif/tb_zx_paging_unit.sv

/* Makefile */
# Verilator build and run for the paging unit testbench

VERILATOR ?= verilator
TOP       ?= tb_zx_paging_unit
RTL_TOP   ?= zx_paging_unit
FILELIST  ?= zx_paging_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
LINTFLAGS ?= -Wall
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

# Fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINTFLAGS) -f $(FILELIST) \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
